/* design/rsPkg.sv */
package rsPkg;

    // Datapath and table sizes
    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int tagWidth     = 4;
    localparam int numRegs      = 32;

    // Station banks
    localparam int numAdd     = 3;
    localparam int numMul     = 2;
    localparam int addTagBase = 1;
    localparam int mulTagBase = 4;

    typedef logic [wordWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Zero means the value is present and has no producer
    typedef logic [tagWidth-1:0] tagT;

    // One instruction offered for issue, add wins over multiply
    typedef struct packed {
        logic    addEn;
        logic    mulEn;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        logic    isImm;
        wordT    imm;
    } issueReqT;

    // Sourced operand pair, a value is valid only where its tag is zero
    typedef struct packed {
        wordT vj;
        wordT vk;
        tagT  qj;
        tagT  qk;
    } operandT;

    // Start pulse toward one functional unit
    typedef struct packed {
        logic start;
        wordT srcA;
        wordT srcB;
        tagT  tag;
    } dispatchT;

    // Common data bus
    typedef struct packed {
        logic valid;
        tagT  tag;
        wordT data;
    } cdbT;

    // Register file write port
    typedef struct packed {
        logic    valid;
        regAddrT addr;
        wordT    data;
    } regWriteT;

endpackage

/* design/registerStatus.sv */
`timescale 1ns/1ps

module registerStatus (
    input  logic            clk,
    input  logic            reset,
    input  rsPkg::issueReqT issue,
    input  rsPkg::wordT     readData1,
    input  rsPkg::wordT     readData2,
    input  logic            addFull,
    input  logic            mulFull,
    input  rsPkg::tagT      addTag,
    input  rsPkg::tagT      mulTag,
    input  rsPkg::cdbT      cdb,
    output rsPkg::operandT  operands,
    output logic            stall,
    output rsPkg::regWriteT regWrite
);
    import rsPkg::*;

    // Producer tag of every architectural register
    tagT regStat [numRegs];

    tagT     srcTagJ;
    tagT     srcTagK;
    logic    addAccept;
    logic    mulAccept;
    logic    accept;
    tagT     newTag;
    logic    wbHit;
    regAddrT wbAddr;
    logic    wbValid;
    regAddrT wbAddrQ;
    wordT    wbData;

    assign srcTagJ = regStat[issue.rs];
    assign srcTagK = regStat[issue.rt];

    // Chosen bank is add when both enables are high
    assign addAccept = issue.addEn && !addFull;
    assign mulAccept = !issue.addEn && issue.mulEn && !mulFull;
    assign accept    = addAccept || mulAccept;
    assign newTag    = issue.addEn ? addTag : mulTag;
    assign stall     = (issue.addEn && addFull) || (!issue.addEn && issue.mulEn && mulFull);

    // Operand sourcing, a result on the CDB this cycle is forwarded
    always_comb begin
        operands = '0;
        if (srcTagJ != '0 && cdb.valid && cdb.tag == srcTagJ) begin
            operands.vj = cdb.data;
        end else if (srcTagJ != '0) begin
            operands.qj = srcTagJ;
        end else begin
            operands.vj = readData1;
        end

        if (issue.isImm) begin
            operands.vk = issue.imm;
        end else if (srcTagK != '0 && cdb.valid && cdb.tag == srcTagK) begin
            operands.vk = cdb.data;
        end else if (srcTagK != '0) begin
            operands.qk = srcTagK;
        end else begin
            operands.vk = readData2;
        end
    end

    // At most one register waits on a given tag
    always_comb begin
        wbHit  = 1'b0;
        wbAddr = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (cdb.valid && regStat[i] != '0 && regStat[i] == cdb.tag) begin
                wbHit  = 1'b1;
                wbAddr = regAddrT'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regStat[i] <= '0;
            end
            wbValid <= 1'b0;
        end else begin
            wbValid <= wbHit;
            for (int i = 0; i < numRegs; i++) begin
                if (cdb.valid && regStat[i] == cdb.tag) begin
                    regStat[i] <= '0;
                end
            end
            // Rename overrides a clear of the same register
            if (accept && issue.rd != '0) begin
                regStat[issue.rd] <= newTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wbHit) begin
            wbAddrQ <= wbAddr;
            wbData  <= cdb.data;
        end
    end

    assign regWrite = '{valid: wbValid, addr: wbAddrQ, data: wbData};

    // Tag zero would match every idle status entry
    cdbTagNonZero: assert property (
        @(posedge clk) disable iff (reset)
        cdb.valid |-> cdb.tag != '0
    );

endmodule

/* design/stationBank.sv */
`timescale 1ns/1ps

module stationBank #(
    parameter int numEntries = 3,
    parameter int firstTag   = 1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            en,
    input  rsPkg::operandT  operands,
    input  rsPkg::cdbT      cdb,
    output rsPkg::tagT      allocTag,
    output logic            full,
    output rsPkg::dispatchT dispatch [numEntries]
);
    import rsPkg::*;

    localparam int idxWidth = (numEntries > 1) ? $clog2(numEntries) : 1;

    // Control state per station
    logic [numEntries-1:0] busy;
    logic [numEntries-1:0] fired;
    logic [numEntries-1:0] start;

    // Operand payload per station
    operandT slot [numEntries];
    wordT    srcA [numEntries];
    wordT    srcB [numEntries];

    logic [numEntries-1:0] ready;
    logic [numEntries-1:0] ownHit;
    logic [numEntries-1:0] hitJ;
    logic [numEntries-1:0] hitK;
    logic [idxWidth-1:0]   allocIdx;
    logic                  write;

    // Lowest free station
    always_comb begin
        allocIdx = '0;
        for (int i = numEntries - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                allocIdx = idxWidth'(i);
            end
        end
    end

    assign full     = &busy;
    assign write    = en && !full;
    assign allocTag = tagT'(firstTag) + tagT'(allocIdx);

    for (genvar i = 0; i < numEntries; i++) begin : gEntry
        assign ready[i]  = busy[i] && !fired[i] && slot[i].qj == '0 && slot[i].qk == '0;
        assign ownHit[i] = cdb.valid && cdb.tag == tagT'(firstTag + i);
        assign hitJ[i]   = cdb.valid && slot[i].qj != '0 && slot[i].qj == cdb.tag;
        assign hitK[i]   = cdb.valid && slot[i].qk != '0 && slot[i].qk == cdb.tag;

        assign dispatch[i] = '{
            start: start[i],
            srcA:  srcA[i],
            srcB:  srcB[i],
            tag:   tagT'(firstTag + i)
        };

        // Results come back only for stations already sent to their unit
        ownTagBusyFired: assert property (
            @(posedge clk) disable iff (reset)
            ownHit[i] |-> busy[i] && fired[i]
        );

        startWhileBusy: assert property (
            @(posedge clk) disable iff (reset)
            start[i] |-> busy[i]
        );
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            fired <= '0;
            start <= '0;
        end else begin
            for (int i = 0; i < numEntries; i++) begin
                start[i] <= ready[i];
                if (ready[i]) begin
                    fired[i] <= 1'b1;
                end
                if (ownHit[i]) begin
                    busy[i]  <= 1'b0;
                    fired[i] <= 1'b0;
                end
                if (write && allocIdx == idxWidth'(i)) begin
                    busy[i]  <= 1'b1;
                    fired[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < numEntries; i++) begin
            if (write && allocIdx == idxWidth'(i)) begin
                slot[i] <= operands;
            end else begin
                // Capture broadcast results into waiting operands
                if (hitJ[i]) begin
                    slot[i].vj <= cdb.data;
                    slot[i].qj <= '0;
                end
                if (hitK[i]) begin
                    slot[i].vk <= cdb.data;
                    slot[i].qk <= '0;
                end
            end
            if (ready[i]) begin
                srcA[i] <= slot[i].vj;
                srcB[i] <= slot[i].vk;
            end
        end
    end

endmodule

/* design/reservationStation.sv */
`timescale 1ns/1ps

module reservationStation (
    input  logic            clk,
    input  logic            reset,
    input  rsPkg::issueReqT issue,
    output rsPkg::regAddrT  readAddr1,
    output rsPkg::regAddrT  readAddr2,
    input  rsPkg::wordT     readData1,
    input  rsPkg::wordT     readData2,
    output logic            stall,
    output rsPkg::dispatchT addDispatch [rsPkg::numAdd],
    output rsPkg::dispatchT mulDispatch [rsPkg::numMul],
    input  rsPkg::cdbT      cdb,
    output rsPkg::regWriteT regWrite
);
    import rsPkg::*;

    operandT operands;
    tagT     addTag;
    tagT     mulTag;
    logic    addFull;
    logic    mulFull;
    logic    mulEn;

    // Register file is read with the source fields directly
    assign readAddr1 = issue.rs;
    assign readAddr2 = issue.rt;

    // Multiply issues only when no add is offered
    assign mulEn = issue.mulEn && !issue.addEn;

    registerStatus status (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .readData1 (readData1),
        .readData2 (readData2),
        .addFull   (addFull),
        .mulFull   (mulFull),
        .addTag    (addTag),
        .mulTag    (mulTag),
        .cdb       (cdb),
        .operands  (operands),
        .stall     (stall),
        .regWrite  (regWrite)
    );

    stationBank #(
        .numEntries (numAdd),
        .firstTag   (addTagBase)
    ) addBank (
        .clk      (clk),
        .reset    (reset),
        .en       (issue.addEn),
        .operands (operands),
        .cdb      (cdb),
        .allocTag (addTag),
        .full     (addFull),
        .dispatch (addDispatch)
    );

    stationBank #(
        .numEntries (numMul),
        .firstTag   (mulTagBase)
    ) mulBank (
        .clk      (clk),
        .reset    (reset),
        .en       (mulEn),
        .operands (operands),
        .cdb      (cdb),
        .allocTag (mulTag),
        .full     (mulFull),
        .dispatch (mulDispatch)
    );

endmodule

/* test/unitModel.sv */
`timescale 1ns/1ps

module unitModel #(
    parameter logic [31:0] seedInit = 32'd1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            slow,
    input  rsPkg::dispatchT addDispatch [rsPkg::numAdd],
    input  rsPkg::dispatchT mulDispatch [rsPkg::numMul],
    output rsPkg::cdbT      cdb
);
    import rsPkg::*;

    // Result waiting for its turn on the CDB
    typedef struct packed {
        tagT         tag;
        wordT        data;
        logic [31:0] due;
    } pendingT;

    pendingT     pending [$];
    integer      seed;
    logic [31:0] now;

    function automatic logic [31:0] latency();
        if (slow) begin
            return 32'd6;
        end
        return 32'd1 + ($unsigned($random(seed)) % 6);
    endfunction

    initial begin
        seed = seedInit;
        now  = '0;
        cdb  = '0;
    end

    // Both units take a new start every cycle
    always @(negedge clk) begin
        pendingT p;
        if (!reset) begin
            now = now + 1;
            for (int i = 0; i < numAdd; i++) begin
                if (addDispatch[i].start) begin
                    p.tag  = addDispatch[i].tag;
                    p.data = addDispatch[i].srcA + addDispatch[i].srcB;
                    p.due  = now + latency();
                    pending.push_back(p);
                end
            end
            for (int i = 0; i < numMul; i++) begin
                if (mulDispatch[i].start) begin
                    p.tag  = mulDispatch[i].tag;
                    p.data = mulDispatch[i].srcA * mulDispatch[i].srcB;
                    p.due  = now + latency();
                    pending.push_back(p);
                end
            end
        end
    end

    // Oldest due result wins the bus
    always @(posedge clk) begin
        cdbT  bus;
        logic found;
        #2;
        bus   = '0;
        found = 1'b0;
        for (int i = 0; i < pending.size(); i++) begin
            if (!found && pending[i].due <= now) begin
                bus   = '{valid: 1'b1, tag: pending[i].tag, data: pending[i].data};
                found = 1'b1;
                pending.delete(i);
            end
        end
        cdb = bus;
    end

endmodule

/* test/tbReservationStation.sv */
`timescale 1ns/1ps

module tbReservationStation;
    import rsPkg::*;

    localparam logic [31:0] seedInit = 32'hd5f1_0f64;
    localparam int timeoutCycles = 2000;
    localparam int numTags       = mulTagBase + numMul;
    localparam int opAdd         = 0;
    localparam int opAddImm      = 1;
    localparam int opMul         = 2;

    logic     clk;
    logic     reset;
    logic     slow;
    issueReqT issue;
    regAddrT  readAddr1;
    regAddrT  readAddr2;
    wordT     readData1;
    wordT     readData2;
    logic     stall;
    dispatchT addDispatch [numAdd];
    dispatchT mulDispatch [numMul];
    cdbT      cdb;
    regWriteT regWrite;

    issueReqT prog [$];
    wordT     expA [$];
    wordT     expB [$];
    wordT     expRes [$];
    wordT     refRegs [numRegs];
    wordT     regFile [numRegs];

    // Expected station occupancy and register renaming
    logic     tagBusy [numTags];
    int       tagInstr [numTags];
    logic     expPending [numTags];
    dispatchT expDispatch [numTags];
    int       lastWriter [numRegs];
    regWriteT expWrite;
    int       issueIdx;
    int       issuedCount;
    int       doneCount;
    int       stallCycles;
    integer   seed;
    string    testName;

    reservationStation dut (.*);
    unitModel #(.seedInit(seedInit)) units (.*);

    // Write-through register file
    assign readData1 = regFile[readAddr1];
    assign readData2 = regFile[readAddr2];

    always #20 clk = ~clk;

    function automatic wordT initValue(int r);
        return (32'h9e37_79b9 * (r + 1)) ^ {r[7:0], ~r[7:0], r[7:0], 8'h5a};
    endfunction

    function automatic issueReqT makeInstr(int op, int rd, int rs, int rt, wordT imm);
        issueReqT q;
        q       = '0;
        q.addEn = (op != opMul);
        q.mulEn = (op == opMul);
        q.isImm = (op == opAddImm);
        q.rd    = regAddrT'(rd);
        q.rs    = regAddrT'(rs);
        q.rt    = regAddrT'(rt);
        q.imm   = q.isImm ? imm : '0;
        return q;
    endfunction

    function automatic void buildProgram();
        int op;
        int rd;
        int rs;
        int rt;
        prog.push_back(makeInstr(opAdd, 1, 2, 3, 0));
        prog.push_back(makeInstr(opAddImm, 4, 5, 0, 32'h0000_0123));
        prog.push_back(makeInstr(opAdd, 6, 1, 4, 0));
        prog.push_back(makeInstr(opMul, 7, 6, 2, 0));
        prog.push_back(makeInstr(opAdd, 8, 2, 3, 0));
        prog.push_back(makeInstr(opMul, 9, 8, 3, 0));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(makeInstr(opAdd, 14 + i, 10 + i, 1, 0));
        end
        // Two writes to r11, a write to r0, then readers of both
        prog.push_back(makeInstr(opAdd, 11, 1, 2, 0));
        prog.push_back(makeInstr(opAdd, 11, 3, 4, 0));
        prog.push_back(makeInstr(opAdd, 0, 5, 6, 0));
        prog.push_back(makeInstr(opMul, 12, 0, 1, 0));
        prog.push_back(makeInstr(opAdd, 13, 11, 1, 0));
        for (int i = 0; i < 200; i++) begin
            op = $unsigned($random(seed)) % 3;
            rd = $unsigned($random(seed)) % 8;
            rs = $unsigned($random(seed)) % 8;
            rt = $unsigned($random(seed)) % 8;
            prog.push_back(makeInstr(op, rd, rs, rt, $random(seed)));
        end
    endfunction

    // Program order, wrapping 32-bit arithmetic
    function automatic void runReference();
        wordT a;
        wordT b;
        wordT r;
        for (int i = 0; i < numRegs; i++) begin
            refRegs[i] = initValue(i);
        end
        for (int i = 0; i < prog.size(); i++) begin
            a = refRegs[prog[i].rs];
            b = prog[i].isImm ? prog[i].imm : refRegs[prog[i].rt];
            r = prog[i].addEn ? a + b : a * b;
            expA.push_back(a);
            expB.push_back(b);
            expRes.push_back(r);
            if (prog[i].rd != '0) begin
                refRegs[prog[i].rd] = r;
            end
        end
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkDispatch(input string name, input dispatchT exp, input dispatchT act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                testName, name, exp, act));
        end
    endtask

    task automatic checkRegWrite(input string name, input regWriteT exp, input regWriteT act);
        if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
            failRun($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                testName, name, exp, act));
        end
    endtask

    task automatic checkLevel(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                testName, name, exp, act));
        end
    endtask

    task automatic checkStart(input dispatchT d);
        if (d.start) begin
            if (!expPending[d.tag]) begin
                failRun($sformatf("dispatch on tag %0d with no instruction waiting", d.tag));
            end
            checkDispatch("dispatch", expDispatch[d.tag], d);
            expPending[d.tag] = 1'b0;
        end
    endtask

    function automatic logic bankFull(int base, int count);
        logic full;
        full = 1'b1;
        for (int t = base; t < base + count; t++) begin
            full = full & tagBusy[t];
        end
        return full;
    endfunction

    function automatic int lowestFree(int base, int count);
        int t;
        t = base;
        while (t < base + count - 1 && tagBusy[t]) begin
            t++;
        end
        return t;
    endfunction

    always @(negedge clk) begin
        regWriteT nextWrite;
        logic     expStall;
        int       t;
        if (!reset) begin
            for (int k = 0; k < numAdd; k++) begin
                checkStart(addDispatch[k]);
            end
            for (int k = 0; k < numMul; k++) begin
                checkStart(mulDispatch[k]);
            end
            checkRegWrite("register write", expWrite, regWrite);
            if (regWrite.valid) begin
                regFile[regWrite.addr] = regWrite.data;
            end
            expStall = issue.addEn ? bankFull(addTagBase, numAdd)
                                   : issue.mulEn && bankFull(mulTagBase, numMul);
            checkLevel("stall", expStall, stall);
            nextWrite = '0;
            if (cdb.valid) begin
                t = tagInstr[cdb.tag];
                // Only the newest writer of a register reaches the file
                if (prog[t].rd != '0 && lastWriter[prog[t].rd] == t) begin
                    nextWrite = '{valid: 1'b1, addr: prog[t].rd, data: expRes[t]};
                end
                doneCount++;
            end
            if ((issue.addEn || issue.mulEn) && !stall) begin
                t = issue.addEn ? lowestFree(addTagBase, numAdd) : lowestFree(mulTagBase, numMul);
                tagBusy[t]     = 1'b1;
                tagInstr[t]    = issueIdx;
                expPending[t]  = 1'b1;
                expDispatch[t] = '{start: 1'b1, srcA: expA[issueIdx], srcB: expB[issueIdx],
                                   tag: tagT'(t)};
                if (issue.rd != '0) begin
                    lastWriter[issue.rd] = issueIdx;
                end
                issuedCount++;
            end
            if (cdb.valid) begin
                tagBusy[cdb.tag] = 1'b0;
            end
            expWrite = nextWrite;
        end
    end

    task automatic driveInstr(input int idx);
        issueIdx = idx;
        issue    = prog[idx];
    endtask

    task automatic issueInstr(input int idx);
        driveInstr(idx);
        stallCycles = 0;
        do begin
            @(negedge clk);
            if (stall) begin
                stallCycles++;
            end
            if (stallCycles > timeoutCycles) begin
                failRun("timed out waiting for stall to fall");
            end
        end while (stall);
        @(posedge clk);
        #2;
        issue = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic waitIdle();
        int count;
        count = 0;
        while (doneCount != issuedCount || expWrite.valid || regWrite.valid) begin
            @(posedge clk);
            #2;
            count++;
            if (count > timeoutCycles) begin
                failRun("timed out waiting for the stations to drain");
            end
        end
    endtask

    initial begin
        int first;
        clk         = 1'b0;
        reset       = 1'b1;
        slow        = 1'b0;
        issue       = '0;
        seed        = seedInit;
        issueIdx    = 0;
        issuedCount = 0;
        doneCount   = 0;
        expWrite    = '0;
        testName    = "reset";
        for (int t = 0; t < numTags; t++) begin
            tagBusy[t]    = 1'b0;
            expPending[t] = 1'b0;
            tagInstr[t]   = 0;
        end
        for (int r = 0; r < numRegs; r++) begin
            regFile[r]    = initValue(r);
            lastWriter[r] = -1;
        end
        buildProgram();
        runReference();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        testName = "independent add";
        for (int i = 0; i < 2; i++) begin
            issueInstr(i);
            repeat (2) @(negedge clk);
            checkLevel("start one cycle after issue", 1'b1, addDispatch[i].start);
            @(posedge clk);
            #2;
        end
        waitIdle();

        testName = "dependency chain";
        issueInstr(2);
        issueInstr(3);
        waitIdle();

        // Six cycle units put the producer on the CDB at the dependent's issue edge
        testName = "same-cycle forwarding";
        slow     = 1'b1;
        issueInstr(4);
        idle(8);
        driveInstr(5);
        @(negedge clk);
        checkLevel("source on CDB at issue", 1'b1, cdb.valid && cdb.tag == tagT'(addTagBase));
        @(posedge clk);
        #2;
        issue = '0;
        waitIdle();

        testName = "stall";
        for (int i = 6; i < 9; i++) begin
            issueInstr(i);
        end
        first = doneCount;
        issueInstr(9);
        checkLevel("stall on fourth add", 1'b1, stallCycles > 0);
        checkLevel("fourth add after broadcast", 1'b1, doneCount > first);
        waitIdle();

        testName = "write after write";
        for (int i = 10; i < 15; i++) begin
            issueInstr(i);
        end
        waitIdle();

        testName = "random program";
        slow     = 1'b0;
        for (int i = 15; i < prog.size(); i++) begin
            issueInstr(i);
        end
        waitIdle();
        for (int r = 0; r < numRegs; r++) begin
            checkRegWrite("final register",
                regWriteT'{valid: 1'b1, addr: regAddrT'(r), data: refRegs[r]},
                regWriteT'{valid: 1'b1, addr: regAddrT'(r), data: regFile[r]});
        end
        $display("test passed");
        $finish;
    end

endmodule

/* filelist.f */
design/rsPkg.sv
design/registerStatus.sv
design/stationBank.sv
design/reservationStation.sv
test/unitModel.sv
test/tbReservationStation.sv

/* Bender.yml */
package:
  name: reservationStation

sources:
  - design/rsPkg.sv
  - design/registerStatus.sv
  - design/stationBank.sv
  - design/reservationStation.sv
  - target: test
    files:
      - test/unitModel.sv
      - test/tbReservationStation.sv
